//--- cpu_pkg.sv
package cpu_pkg;

	// ============================================================
	// major opcodes and exception causes
	// ============================================================

	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_AUIPC  = 7'b0010111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_REG    = 7'b0110011;
	localparam logic [6:0] OP_SYSTEM = 7'b1110011;

	localparam logic [31:0] cause_ill_inst = 32'd2;
	localparam logic [31:0] cause_ecall_m  = 32'd11;

	// ============================================================
	// operation codes
	// ============================================================

	typedef enum logic [2:0] {wb_alu, wb_mem, wb_pc4, wb_csr, wb_mdu} wb_src_e;

	// the last six are the branch compares.
	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor, alu_srl, alu_sra,
		alu_or, alu_and, alu_eq, alu_ne, alu_lt, alu_ge, alu_ltu, alu_geu
	} alu_op_e;

	// bit 2 marks an unsigned load, the low bits give the access size.
	typedef enum logic [2:0] {
		mem_none = 3'd0, mem_b = 3'd1, mem_h = 3'd2, mem_w = 3'd3, mem_bu = 3'd5, mem_hu = 3'd6
	} mem_op_e;

	typedef enum logic [1:0] {csr_none, csr_rw, csr_rs, csr_rc} csr_op_e;

	// same order as funct3 of the M extension.
	typedef enum logic [2:0] {
		mdu_mul, mdu_mulh, mdu_mulhsu, mdu_mulhu, mdu_div, mdu_divu, mdu_rem, mdu_remu
	} mdu_op_e;

	// ============================================================
	// records
	// ============================================================

	typedef struct packed {
		logic [31:0] immediate;
		logic        rs1_rena;
		logic [4:0]  rs1_addr;
		logic        rs2_rena;
		logic [4:0]  rs2_addr;
		logic        rd_wena;
		logic [4:0]  rd_addr;
		logic [11:0] csr_addr;
		logic        csr_rena;
		logic        csr_wena;
		logic        sel_pc;
		logic        sel_im;
		wb_src_e     wb_src;
		alu_op_e     alu_op;
		mem_op_e     mem_op;
		csr_op_e     csr_op;
		mdu_op_e     mdu_op;
		logic        jump_ena;
		logic        jump_ind;
		logic        jump_alw;
		logic        env_call;
		logic        trap_ret;
		logic        illegal_inst;
	} decode_t;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] ir;
		logic [31:0] immediate;
		logic        rs1_rena;
		logic [4:0]  rs1_addr;
		logic        rs2_rena;
		logic [4:0]  rs2_addr;
		logic        rd_wena;
		logic [4:0]  rd_addr;
		logic [11:0] csr_addr;
		logic        csr_rena;
		logic        csr_wena;
		logic        sel_pc;
		logic        sel_im;
		wb_src_e     wb_src;
		alu_op_e     alu_op;
		mem_op_e     mem_op;
		csr_op_e     csr_op;
		mdu_op_e     mdu_op;
		logic        jump_ena;
		logic        jump_ind;
		logic        jump_alw;
		logic        trap_ret;
		logic [31:0] rs1_data;
		logic [31:0] rs2_data;
		logic        jump_pred;
		logic        exc_pend;
		logic [31:0] exc_cause;
	} id_ex_t;

	typedef struct packed {
		logic        wena;
		logic [4:0]  addr;
		logic [31:0] data;
	} reg_wr_t;

	typedef struct packed {
		logic        valid;
		logic        jump_alw;
		logic        taken;
		logic [31:0] pc;
	} jump_res_t;

endpackage

//--- inst_decoder.sv
`timescale 1ns/1ns

module inst_decoder import cpu_pkg::*; (
	input	logic	[31:0]	ir,
	input	logic			m_ena,
	output	decode_t		dec
);

	logic	[6:0]	opcode;
	logic	[2:0]	funct3;
	logic	[6:0]	funct7;
	logic	[31:0]	imm_i;
	logic	[31:0]	imm_s;
	logic	[31:0]	imm_b;
	logic	[31:0]	imm_u;
	logic	[31:0]	imm_j;
	logic			shift;

	assign opcode = ir[6:0];
	assign funct3 = ir[14:12];
	assign funct7 = ir[31:25];

	assign imm_i = {{20{ir[31]}}, ir[31:20]};
	assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
	assign imm_b = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
	assign imm_u = {ir[31:12], 12'h000};
	assign imm_j = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

	assign shift = funct3[1:0] == 2'b01;	// slli, srli and srai.

	function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  return alt ? alu_sub : alu_add;
			3'b001:  return alu_sll;
			3'b010:  return alu_slt;
			3'b011:  return alu_sltu;
			3'b100:  return alu_xor;
			3'b101:  return alt ? alu_sra : alu_srl;
			3'b110:  return alu_or;
			default: return alu_and;
		endcase
	endfunction

	function automatic alu_op_e branch_op(input logic [2:0] f3);
		case (f3)
			3'b000:  return alu_eq;
			3'b001:  return alu_ne;
			3'b100:  return alu_lt;
			3'b101:  return alu_ge;
			3'b110:  return alu_ltu;
			default: return alu_geu;
		endcase
	endfunction

	always_comb begin
		dec        = '0;
		dec.wb_src = wb_alu;
		dec.alu_op = alu_add;
		dec.mem_op = mem_none;
		dec.csr_op = csr_none;
		dec.mdu_op = mdu_mul;

		case (opcode)
			OP_LUI: begin
				dec.immediate = imm_u;
				dec.rd_wena   = 1'b1;
				dec.sel_im    = 1'b1;	// x0 plus immediate.
			end
			OP_AUIPC: begin
				dec.immediate = imm_u;
				dec.rd_wena   = 1'b1;
				dec.sel_pc    = 1'b1;
				dec.sel_im    = 1'b1;
			end
			OP_JAL: begin
				dec.immediate = imm_j;
				dec.rd_wena   = 1'b1;
				dec.wb_src    = wb_pc4;
				dec.sel_pc    = 1'b1;
				dec.sel_im    = 1'b1;
				dec.jump_ena  = 1'b1;
				dec.jump_alw  = 1'b1;
			end
			OP_JALR: begin
				dec.immediate    = imm_i;
				dec.rs1_rena     = 1'b1;
				dec.rd_wena      = 1'b1;
				dec.wb_src       = wb_pc4;
				dec.sel_im       = 1'b1;
				dec.jump_ena     = 1'b1;
				dec.jump_alw     = 1'b1;
				dec.jump_ind     = 1'b1;
				dec.illegal_inst = funct3 != 3'b000;
			end
			OP_BRANCH: begin
				dec.immediate    = imm_b;
				dec.rs1_rena     = 1'b1;
				dec.rs2_rena     = 1'b1;
				dec.jump_ena     = 1'b1;
				dec.alu_op       = branch_op(funct3);
				dec.illegal_inst = funct3[2:1] == 2'b01;
			end
			OP_LOAD: begin
				dec.immediate    = imm_i;
				dec.rs1_rena     = 1'b1;
				dec.rd_wena      = 1'b1;
				dec.wb_src       = wb_mem;
				dec.sel_im       = 1'b1;
				dec.mem_op       = mem_op_e'({funct3[2], funct3[1:0] + 2'd1});
				dec.illegal_inst = funct3[1:0] == 2'b11 || funct3[2:1] == 2'b11;
			end
			OP_STORE: begin
				dec.immediate    = imm_s;
				dec.rs1_rena     = 1'b1;
				dec.rs2_rena     = 1'b1;
				dec.sel_im       = 1'b1;
				dec.mem_op       = mem_op_e'({1'b0, funct3[1:0] + 2'd1});
				dec.illegal_inst = funct3[2] || funct3[1:0] == 2'b11;
			end
			OP_IMM: begin
				dec.immediate    = imm_i;
				dec.rs1_rena     = 1'b1;
				dec.rd_wena      = 1'b1;
				dec.sel_im       = 1'b1;
				dec.alu_op       = arith_op(funct3, shift && funct7[5]);
				dec.illegal_inst = shift && !(funct7 == 7'b0000000 ||
					(funct3[2] && funct7 == 7'b0100000));
			end
			OP_REG: begin
				dec.rs1_rena = 1'b1;
				dec.rs2_rena = 1'b1;
				dec.rd_wena  = 1'b1;
				if (funct7 == 7'b0000001) begin
					dec.wb_src       = wb_mdu;
					dec.mdu_op       = mdu_op_e'(funct3);
					dec.illegal_inst = !m_ena;
				end else begin
					dec.alu_op       = arith_op(funct3, funct7[5]);
					dec.illegal_inst = !(funct7 == 7'b0000000 || (funct7 == 7'b0100000 &&
						(funct3 == 3'b000 || funct3 == 3'b101)));
				end
			end
			OP_SYSTEM: begin
				if (funct3 == 3'b000) begin
					if (ir == 32'h00000073)
						dec.env_call = 1'b1;
					else if (ir == 32'h30200073) begin	// mret.
						dec.trap_ret = 1'b1;
						dec.jump_ena = 1'b1;
						dec.jump_alw = 1'b1;
					end else
						dec.illegal_inst = 1'b1;
				end else begin
					// funct3 bit 2 selects the zimm form, the rs1 field is then the operand.
					dec.immediate    = {27'd0, ir[19:15]};
					dec.csr_addr     = ir[31:20];
					dec.rd_wena      = 1'b1;
					dec.wb_src       = wb_csr;
					dec.rs1_rena     = !funct3[2];
					dec.sel_im       = funct3[2];
					dec.csr_op       = csr_op_e'(funct3[1:0]);
					dec.csr_rena     = funct3[1:0] != 2'b01 || ir[11:7] != 5'd0;
					dec.csr_wena     = funct3[1:0] == 2'b01 || ir[19:15] != 5'd0;
					dec.illegal_inst = funct3[1:0] == 2'b00;
				end
			end
			default: dec.illegal_inst = 1'b1;
		endcase

		if (ir[1:0] != 2'b11)
			dec.illegal_inst = 1'b1;	// compressed encodings are not supported.

		// unused register fields read as x0 so that operands are zero.
		dec.rs1_addr = dec.rs1_rena ? ir[19:15] : 5'd0;
		dec.rs2_addr = dec.rs2_rena ? ir[24:20] : 5'd0;
		dec.rd_addr  = dec.rd_wena ? ir[11:7] : 5'd0;
	end

endmodule

//--- reg_file.sv
`timescale 1ns/1ns

module reg_file import cpu_pkg::*; (
	input	logic			clk,
	input	logic	[4:0]	rs1_addr,
	input	logic	[4:0]	rs2_addr,
	output	logic	[31:0]	rs1_data,
	output	logic	[31:0]	rs2_data,
	input	reg_wr_t		wr
);

	logic	[31:0]	regs	[1:31];	// x0 has no storage.

	// no bypass, a read during a write sees the old value.
	assign rs1_data = rs1_addr == 5'd0 ? 32'd0 : regs[rs1_addr];
	assign rs2_data = rs2_addr == 5'd0 ? 32'd0 : regs[rs2_addr];

	always_ff @(posedge clk) begin
		if (wr.wena && wr.addr != 5'd0)
			regs[wr.addr] <= wr.data;
	end

	assert property (@(posedge clk) wr.wena |-> !$isunknown(wr.addr))
		else $error("register write with unknown address");

endmodule

//--- branch_predictor.sv
`timescale 1ns/1ns

module branch_predictor import cpu_pkg::*; #(
	parameter int index_bits   = 3,
	parameter int counter_bits = 2
) (
	input	logic			clk,
	input	logic			reset,
	input	logic			valid_in,
	input	logic	[31:0]	pc,
	input	decode_t		dec,
	input	logic	[31:0]	trap_raddr,
	output	logic			jump_pred,
	output	logic	[31:0]	jump_addr,
	input	jump_res_t		res
);

	localparam int entries = 2 ** index_bits;

	logic	[counter_bits-1:0]	counters	[entries];
	logic	[index_bits-1:0]	rd_idx;
	logic	[index_bits-1:0]	wr_idx;
	logic						ctr_taken;

	assign rd_idx    = pc[index_bits+1:2];
	assign wr_idx    = res.pc[index_bits+1:2];
	assign ctr_taken = counters[rd_idx][counter_bits-1];

	always_comb begin
		jump_pred = 1'b0;
		jump_addr = pc + dec.immediate;
		if (valid_in) begin
			if (dec.trap_ret) begin
				jump_pred = 1'b1;
				jump_addr = trap_raddr;
			end else if (dec.jump_ena && dec.jump_alw)
				jump_pred = !dec.jump_ind;	// jalr targets are left to execute.
			else if (dec.jump_ena)
				jump_pred = ctr_taken;
		end
	end

	// only conditional branches train the table.
	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			for (int i = 0; i < entries; i++)
				counters[i] <= counter_bits'(1);	// weakly not taken.
		end else if (res.valid && !res.jump_alw) begin
			if (res.taken && counters[wr_idx] != '1)
				counters[wr_idx] <= counters[wr_idx] + 1'b1;
			else if (!res.taken && counters[wr_idx] != '0)
				counters[wr_idx] <= counters[wr_idx] - 1'b1;
		end
	end

	assert property (@(posedge clk) disable iff (reset) !valid_in |-> !jump_pred)
		else $error("prediction without a valid instruction");

endmodule

//--- id_stage.sv
`timescale 1ns/1ns

module id_stage import cpu_pkg::*; (
	input	logic			clk,
	input	logic			reset,
	input	logic			flush,
	input	logic			valid_in,
	output	logic			ready_out,
	output	logic			valid_out,
	input	logic			ready_in,
	output	logic			valid_mdu,
	input	logic			ready_mdu,
	input	logic	[31:0]	pc_if,
	input	logic	[31:0]	ir_if,
	input	logic			exc_pend_if,
	input	logic	[31:0]	exc_cause_if,
	input	decode_t		dec,
	input	logic	[31:0]	rs1_data,
	input	logic	[31:0]	rs2_data,
	input	logic			jump_pred_if,
	output	id_ex_t			id_ex
);

	logic			valid_q;
	logic			mdu_q;
	logic			stall;
	logic			exc_pend;
	logic	[31:0]	exc_cause;
	id_ex_t			rec_in;

	assign valid_out = valid_q && !flush;
	assign valid_mdu = mdu_q && valid_out;

	// a CSR access holds off the next instruction until it leaves.
	assign stall     = id_ex.csr_rena || id_ex.csr_wena;
	assign ready_out = ready_in && !stall;

	// ============================================================
	// exception priority
	// ============================================================

	always_comb begin
		exc_pend  = 1'b1;
		exc_cause = 32'd0;
		if (exc_pend_if)
			exc_cause = exc_cause_if;
		else if (dec.illegal_inst)
			exc_cause = cause_ill_inst;
		else if (dec.env_call)
			exc_cause = cause_ecall_m;
		else
			exc_pend = 1'b0;
	end

	always_comb begin
		rec_in.pc        = pc_if;
		rec_in.ir        = ir_if;
		rec_in.immediate = dec.immediate;
		rec_in.rs1_rena  = dec.rs1_rena;
		rec_in.rs1_addr  = dec.rs1_addr;
		rec_in.rs2_rena  = dec.rs2_rena;
		rec_in.rs2_addr  = dec.rs2_addr;
		rec_in.rd_wena   = dec.rd_wena && !exc_pend;
		rec_in.rd_addr   = dec.rd_addr;
		rec_in.csr_addr  = dec.csr_addr;
		rec_in.csr_rena  = dec.csr_rena;
		rec_in.csr_wena  = dec.csr_wena && !exc_pend;
		rec_in.sel_pc    = dec.sel_pc;
		rec_in.sel_im    = dec.sel_im;
		rec_in.wb_src    = dec.wb_src;
		rec_in.alu_op    = dec.alu_op;
		rec_in.mem_op    = dec.mem_op;
		rec_in.csr_op    = dec.csr_op;
		rec_in.mdu_op    = dec.mdu_op;
		rec_in.jump_ena  = dec.jump_ena;
		rec_in.jump_ind  = dec.jump_ind;
		rec_in.jump_alw  = dec.jump_alw;
		rec_in.trap_ret  = dec.trap_ret;
		rec_in.rs1_data  = rs1_data;
		rec_in.rs2_data  = rs2_data;
		rec_in.jump_pred = jump_pred_if;
		rec_in.exc_pend  = exc_pend;
		rec_in.exc_cause = exc_cause;
	end

	// ============================================================
	// ID/EX register
	// ============================================================

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			valid_q <= 1'b0;
			mdu_q   <= 1'b0;
			id_ex   <= '0;
		end else if (flush) begin
			valid_q <= 1'b0;
			mdu_q   <= 1'b0;
			id_ex   <= '0;
		end else if (valid_in && ready_out) begin	// also covers a transfer on the same edge.
			valid_q <= 1'b1;
			mdu_q   <= dec.wb_src == wb_mdu && !exc_pend;
			id_ex   <= rec_in;
		end else if (valid_q && ready_in) begin
			valid_q <= 1'b0;
			mdu_q   <= 1'b0;
			id_ex   <= '0;
		end else if (mdu_q && ready_mdu)
			mdu_q <= 1'b0;
	end

	assert property (@(posedge clk) disable iff (reset) mdu_q |-> valid_q)
		else $error("multiply/divide dispatch without a held record");

endmodule

//--- decode_top.sv
`timescale 1ns/1ns

module decode_top import cpu_pkg::*; #(
	parameter int index_bits   = 3,
	parameter int counter_bits = 2
) (
	input	logic			clk,
	input	logic			reset,
	input	logic			flush,
	input	logic			valid_in,
	output	logic			ready_out,
	input	logic	[31:0]	pc_if,
	input	logic	[31:0]	ir_if,
	input	logic			exc_pend_if,
	input	logic	[31:0]	exc_cause_if,
	input	logic			m_ena,
	input	logic	[31:0]	trap_raddr,
	output	logic			jump_pred_if,
	output	logic	[31:0]	jump_addr_if,
	output	logic			valid_out,
	input	logic			ready_in,
	output	id_ex_t			id_ex,
	output	logic			valid_mdu,
	input	logic			ready_mdu,
	input	reg_wr_t		wr,
	input	jump_res_t		res
);

	decode_t		dec;
	logic	[31:0]	rs1_data;
	logic	[31:0]	rs2_data;

	inst_decoder u_decoder (
		.ir(ir_if),
		.m_ena(m_ena),
		.dec(dec)
	);

	reg_file u_reg_file (
		.clk(clk),
		.rs1_addr(dec.rs1_addr),
		.rs2_addr(dec.rs2_addr),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.wr(wr)
	);

	branch_predictor #(
		.index_bits(index_bits),
		.counter_bits(counter_bits)
	) u_predictor (
		.clk(clk),
		.reset(reset),
		.valid_in(valid_in),
		.pc(pc_if),
		.dec(dec),
		.trap_raddr(trap_raddr),
		.jump_pred(jump_pred_if),
		.jump_addr(jump_addr_if),
		.res(res)
	);

	id_stage u_id_stage (
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.valid_in(valid_in),
		.ready_out(ready_out),
		.valid_out(valid_out),
		.ready_in(ready_in),
		.valid_mdu(valid_mdu),
		.ready_mdu(ready_mdu),
		.pc_if(pc_if),
		.ir_if(ir_if),
		.exc_pend_if(exc_pend_if),
		.exc_cause_if(exc_cause_if),
		.dec(dec),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.jump_pred_if(jump_pred_if),
		.id_ex(id_ex)
	);

endmodule

//--- tb_decode_top.sv
`timescale 1ns/1ns

module tb_decode_top import cpu_pkg::*; ();

	localparam int max_cases = 64;

	logic			clk;
	logic			reset;
	logic			flush;
	logic			valid_in;
	logic			ready_out;
	logic	[31:0]	pc_if;
	logic	[31:0]	ir_if;
	logic			exc_pend_if;
	logic	[31:0]	exc_cause_if;
	logic			m_ena;
	logic	[31:0]	trap_raddr;
	logic			jump_pred_if;
	logic	[31:0]	jump_addr_if;
	logic			valid_out;
	logic			ready_in;
	id_ex_t			id_ex;
	logic			valid_mdu;
	logic			ready_mdu;
	reg_wr_t		wr;
	jump_res_t		res;

	// columns 0 to 5 are stimulus, 6 to 14 are expected values.
	string			case_name	[$];
	string			case_kind	[$];
	logic	[31:0]	case_val	[max_cases][15];
	string			test_name;
	int				case_errors;
	int				check_errors;
	int				failed_tests;
	int				cycles;
	int				cycle_limit;

	decode_top #(.index_bits(3), .counter_bits(2)) UUT (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		cycles = 0;
		forever begin
			@(posedge clk);
			cycles++;
			if (cycle_limit > 0 && cycles > cycle_limit) begin
				$display("timeout after %0d cycles, the DUT stopped answering", cycles);
				$display("TEST FAIL");
				$finish;
			end
		end
	end

	// ============================================================
	// case file and checks
	// ============================================================

	task automatic read_cases();
		int		fd;
		int		n;
		string	line;
		string	name;
		string	kind;
		fd = $fopen("decode_cases.txt", "r");
		if (fd == 0)
			$display("cannot open decode_cases.txt");
		else begin
			n = 0;
			while (!$feof(fd) && n < max_cases) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 1 && line.substr(0, 0) != "#") begin
					if ($sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						name, kind, case_val[n][0], case_val[n][1], case_val[n][2],
						case_val[n][3], case_val[n][4], case_val[n][5], case_val[n][6],
						case_val[n][7], case_val[n][8], case_val[n][9], case_val[n][10],
						case_val[n][11], case_val[n][12], case_val[n][13],
						case_val[n][14]) == 17) begin
						case_name.push_back(name);
						case_kind.push_back(kind);
						n++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic compare_field(input string field, input logic [31:0] exp,
		input logic [31:0] act);
		assert (act === exp) else begin
			$display("CHECK FAILED %s %s: expected %h, actual %h", test_name, field, exp, act);
			case_errors++;
		end
	endtask

	// ============================================================
	// stimulus
	// ============================================================

	task automatic write_register(input int i);
		wr = {1'b1, case_val[i][0][4:0], case_val[i][1]};
		@(posedge clk);
		#1;
		wr = '0;
	endtask

	task automatic resolve_branch(input int i);
		res = {1'b1, 1'b0, case_val[i][5][0], case_val[i][0]};	// conditional branch only.
		@(posedge clk);
		#1;
		res = '0;
	endtask

	task automatic present_and_accept(input int i);
		logic			pred;
		logic	[31:0]	addr;
		pc_if        = case_val[i][0];
		ir_if        = case_val[i][1];
		exc_pend_if  = case_val[i][2][0];
		exc_cause_if = case_val[i][3];
		m_ena        = case_val[i][4][0];
		valid_in     = 1'b1;
		@(negedge clk);
		while (!ready_out)
			@(negedge clk);
		pred = jump_pred_if;	// the prediction follows the presented word.
		addr = jump_addr_if;
		@(posedge clk);
		#1;
		valid_in = 1'b0;
		ready_in = 1'b0;	// hold the record so that it can be looked at.
		@(negedge clk);
		compare_field("valid_out", 32'd1, 32'(valid_out));
		compare_field("immediate", case_val[i][6], id_ex.immediate);
		compare_field("rd_wena", case_val[i][7], 32'(id_ex.rd_wena));
		compare_field("wb_src", case_val[i][8], 32'(id_ex.wb_src));
		compare_field("exc_pend", case_val[i][9], 32'(id_ex.exc_pend));
		compare_field("exc_cause", case_val[i][10], id_ex.exc_cause);
		compare_field("jump_pred_if", case_val[i][11], 32'(pred));
		compare_field("jump_pred", case_val[i][11], 32'(id_ex.jump_pred));
		if (case_val[i][11][0])
			compare_field("jump_addr_if", case_val[i][12], addr);
		compare_field("rs1_data", case_val[i][13], id_ex.rs1_data);
		compare_field("valid_mdu", case_val[i][14], 32'(valid_mdu));
	endtask

	task automatic hold_and_drain(input int i);
		id_ex_t	held;
		int		n;
		held = id_ex;
		if (case_val[i][5][0]) begin
			n = 1 + int'($urandom % 32'd4);
			repeat (n) begin
				@(negedge clk);
				assert (id_ex === held && valid_out && !ready_out) else begin
					$display("%s: record or handshake changed while ready_in was low",
						test_name);
					case_errors++;
				end
			end
		end
		if (case_val[i][14][0]) begin
			@(posedge clk);
			#1;
			ready_mdu = 1'b1;
			@(posedge clk);
			#1;
			ready_mdu = 1'b0;
			@(negedge clk);
			compare_field("valid_mdu after ack", 32'd0, 32'(valid_mdu));
			compare_field("valid_out after ack", 32'd1, 32'(valid_out));
		end
		@(posedge clk);
		#1;
		ready_in = 1'b1;
		@(negedge clk);
		// a held CSR access keeps the input closed until the record leaves.
		compare_field("ready_out before drain", 32'(case_val[i][8] != 32'd3), 32'(ready_out));
		@(posedge clk);
		#1;
		@(negedge clk);
		compare_field("valid_out after drain", 32'd0, 32'(valid_out));
		compare_field("ready_out after drain", 32'd1, 32'(ready_out));
		@(posedge clk);
		#1;
	endtask

	task automatic apply_flush();
		@(posedge clk);
		#1;
		flush = 1'b1;
		@(negedge clk);
		compare_field("valid_out during flush", 32'd0, 32'(valid_out));
		compare_field("valid_mdu during flush", 32'd0, 32'(valid_mdu));
		@(posedge clk);
		#1;
		flush    = 1'b0;
		ready_in = 1'b1;
		@(negedge clk);
		compare_field("valid_out after flush", 32'd0, 32'(valid_out));
		@(posedge clk);
		#1;
	endtask

	initial begin
		reset        = 1'b1;
		flush        = 1'b0;
		valid_in     = 1'b0;
		pc_if        = '0;
		ir_if        = '0;
		exc_pend_if  = 1'b0;
		exc_cause_if = '0;
		m_ena        = 1'b1;
		trap_raddr   = 32'h00000800;
		ready_in     = 1'b1;
		ready_mdu    = 1'b0;
		wr           = '0;
		res          = '0;
		check_errors = 0;
		failed_tests = 0;
		cycle_limit  = 0;
		void'($urandom(32'h988a9feb));
		read_cases();
		cycle_limit = 40 * case_name.size() + 100;
		if (case_name.size() == 0) begin
			$display("no test cases were read from decode_cases.txt");
			check_errors++;
		end
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		foreach (case_name[i]) begin
			test_name   = case_name[i];
			case_errors = 0;
			if (case_kind[i] == "write")
				write_register(i);
			else if (case_kind[i] == "resolve")
				resolve_branch(i);
			else if (case_kind[i] == "decode") begin
				present_and_accept(i);
				hold_and_drain(i);
			end else if (case_kind[i] == "flush") begin
				present_and_accept(i);
				apply_flush();
			end else begin
				$display("%s: unknown case kind %s", test_name, case_kind[i]);
				case_errors++;
			end
			check_errors += case_errors;
			if (case_errors != 0)
				failed_tests++;
			$display("%s (%s) %s", test_name, case_kind[i], case_errors == 0 ? "ok" : "failed");
		end
		$display("tests run %0d, tests failed %0d, check errors %0d", case_name.size(),
			failed_tests, check_errors);
		if (check_errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

//--- decode_cases.txt
# name kind pc ir fexc fcause m_ena aux  imm rd_wena wb_src exc_pend exc_cause pred paddr rs1 mdu
# write: pc is the register, ir the data. resolve: aux is taken. decode: aux stalls ready_in.
wr_x1 write 1 12345678 0 0 0 0 0 0 0 0 0 0 0 0 0
wr_x0 write 0 deadbeef 0 0 0 0 0 0 0 0 0 0 0 0 0
addi_neg decode 100 ffb08113 0 0 1 1 fffffffb 1 0 0 0 0 0 12345678 0
addi_x0 decode 104 00700193 0 0 1 0 7 1 0 0 0 0 0 0 0
lui decode 108 abcde2b7 0 0 1 0 abcde000 1 0 0 0 0 0 0 0
auipc decode 500 00001617 0 0 1 0 1000 1 0 0 0 0 0 0 0
lw decode 10c 0080a303 0 0 1 0 8 1 1 0 0 0 0 12345678 0
sw decode 110 fe20ae23 0 0 1 0 fffffffc 0 0 0 0 0 0 12345678 0
add_stall decode 114 00208533 0 0 1 1 0 1 0 0 0 0 0 12345678 0
srai decode 118 4030d593 0 0 1 0 403 1 0 0 0 0 0 12345678 0
jal decode 200 010000ef 0 0 1 0 10 1 2 0 0 1 210 0 0
jalr decode 204 000080e7 0 0 1 0 0 1 2 0 0 0 0 12345678 0
beq_cold decode 300 fe208ce3 0 0 1 0 fffffff8 0 0 0 0 0 0 12345678 0
res_t1 resolve 300 0 0 0 0 1 0 0 0 0 0 0 0 0 0
res_t2 resolve 300 0 0 0 0 1 0 0 0 0 0 0 0 0 0
beq_hot decode 300 fe208ce3 0 0 1 0 fffffff8 0 0 0 0 1 2f8 12345678 0
beq_other decode 304 fe208ce3 0 0 1 0 fffffff8 0 0 0 0 0 0 12345678 0
res_nt resolve 300 0 0 0 0 0 0 0 0 0 0 0 0 0 0
beq_still decode 300 fe208ce3 0 0 1 1 fffffff8 0 0 0 0 1 2f8 12345678 0
mret decode 400 30200073 0 0 1 0 0 0 0 0 0 1 800 0 0
ecall decode 404 00000073 0 0 1 0 0 0 0 1 b 0 0 0 0
illegal decode 408 ffffffff 0 0 1 0 0 0 0 1 2 0 0 0 0
fexc_ill decode 40c ffffffff 1 1 1 0 0 0 0 1 1 0 0 0 0
fexc_ecall decode 410 00000073 1 5 1 0 0 0 0 1 5 0 0 0 0
mul_off decode 414 022083b3 0 0 0 0 0 0 4 1 2 0 0 12345678 0
mul_on decode 418 022083b3 0 0 1 1 0 1 4 0 0 0 0 12345678 1
csrrw decode 41c 30009473 0 0 1 1 1 1 3 0 0 0 0 12345678 0
csrrs_ro decode 420 300024f3 0 0 1 0 0 1 3 0 0 0 0 0 0
mul_flush flush 424 022083b3 0 0 1 0 0 1 4 0 0 0 0 12345678 1
wr_x1_new write 1 cafef00d 0 0 0 0 0 0 0 0 0 0 0 0 0
addi_new decode 428 ffb08113 0 0 1 0 fffffffb 1 0 0 0 0 0 cafef00d 0

//--- files.f
cpu_pkg.sv
inst_decoder.sv
reg_file.sv
branch_predictor.sv
id_stage.sv
decode_top.sv
tb_decode_top.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_decode_top -f files.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/Vtb_decode_top)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "TEST PASS"; then
	exit 0
fi
exit 1
